// ==== source/osd_pkg.sv ====
/*
 * OSD menu word layout for the dip settings path.
 * bit positions, the video mode opcode and fx level mask,
 * referenced by scoped name from the latch and decode stages
 */
`default_nettype none

package osd_pkg;

    // widths of the host side words
    localparam int STATUS_W   = 32;
    localparam int CORE_MOD_W = 7;   // core mode word from the framework

    // single bit menu options
    localparam int BIT_FLIP    = 1;  // screen flip, active low in menu
    localparam int BIT_ROT     = 2;  // rotation control
    localparam int BIT_PSG     = 8;  // psg mute
    localparam int BIT_FM      = 9;  // fm mute
    localparam int BIT_TEST    = 10; // service mode
    localparam int BIT_CREDITS = 12; // credits screen pauses the game

    // low bits of multi bit fields
    localparam int VMODE_LO = 3;     // video mode, 2 bits
    localparam int FX_LO    = 6;     // fx volume, 2 bits
    localparam int AR_LO    = 14;    // aspect ratio code, 2 bits

    // video mode opcode in status[4:3]
    typedef enum logic [1:0] {
        VM_PASS          = 2'd0, // pass thru
        VM_LINEAR        = 2'd1, // linear interpolation
        VM_ANALOGUE      = 2'd2, // analogue look
        VM_ANALOGUE_SCAN = 2'd3  // analogue plus scan lines
    } video_mode_e;

    // menu order is high, very high, very low, low
    // xor with this gives a monotonic level
    localparam logic [1:0] FX_INVERT = 2'b10;

endpackage

`default_nettype wire

// ==== source/video_pkg.sv ====
/*
 * Video side definitions for the dip settings path.
 * aspect ratio widths and defaults, scanline field width and
 * the frame sync apply states
 */
`default_nettype none

package video_pkg;

    // hdmi aspect ratio outputs
    localparam int AR_W = 12;

    // most arcade monitors are 4:3
    localparam logic [AR_W-1:0] DEF_ARX = 12'd4;
    localparam logic [AR_W-1:0] DEF_ARY = 12'd3;

    // scanline selector width towards the scaler
    localparam int SCAN_W = 3;

    // frame sync state of the apply stage
    typedef enum logic {
        AP_IDLE    = 1'b0, // outputs match the last decode
        AP_PENDING = 1'b1  // shadow holds settings waiting for vblank
    } apply_state_e;

endpackage

`default_nettype wire

// ==== source/osd_status_if.sv ====
/*
 * Captured OSD status and raw controls, latch stage to decode stage.
 * update pulses one cycle when status or core mode really changed
 */
`timescale 1ns/1ps
`default_nettype none

interface osd_status_if;

    logic [osd_pkg::STATUS_W-1:0]   status;     // held menu word
    logic [osd_pkg::CORE_MOD_W-1:0] core_mod;   // held core mode
    logic                           game_pause; // registered each cycle
    logic                           game_test;  // registered each cycle
    logic                           update;     // one cycle, on change only

    modport src (
        output status, core_mod, game_pause, game_test, update
    );

    modport dst (
        input status, core_mod, game_pause, game_test, update
    );

endinterface

`default_nettype wire

// ==== source/dip_settings_if.sv ====
/*
 * Decoded settings, decode stage to frame sync apply stage.
 * valid pulses one cycle with each new set of values, the values
 * stay stable in between
 */
`timescale 1ns/1ps
`default_nettype none

interface dip_settings_if;

    logic [video_pkg::AR_W-1:0]   hdmi_arx;
    logic [video_pkg::AR_W-1:0]   hdmi_ary;
    logic [1:0]                   rotate;      // {~flip, rotate 90}
    logic                         rot_control;
    logic                         en_mixing;
    logic [video_pkg::SCAN_W-1:0] scanlines;
    logic                         bw_en;
    logic                         blend_en;
    logic                         enable_fm;
    logic                         enable_psg;
    logic                         osd_pause;
    logic                         dip_flip;
    logic [1:0]                   dip_fxlevel;
    logic                         valid;       // new set this cycle

    modport src (
        output hdmi_arx, hdmi_ary, rotate, rot_control, en_mixing,
               scanlines, bw_en, blend_en, enable_fm, enable_psg,
               osd_pause, dip_flip, dip_fxlevel, valid
    );

    modport dst (
        input hdmi_arx, hdmi_ary, rotate, rot_control, en_mixing,
              scanlines, bw_en, blend_en, enable_fm, enable_psg,
              osd_pause, dip_flip, dip_fxlevel, valid
    );

endinterface

`default_nettype wire

// ==== source/osd_status_latch.sv ====
/*
 * First stage. Captures the OSD status word and core mode on
 * status_valid and pulses update only when the captured value differs
 * from the held one, so repeated menu strobes cost nothing downstream.
 * Raw pause and test inputs are registered every cycle.
 */
`timescale 1ns/1ps
`default_nettype none

module osd_status_latch (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic [osd_pkg::STATUS_W-1:0]   status,
    input  wire logic                           status_valid,
    input  wire logic [osd_pkg::CORE_MOD_W-1:0] core_mod,
    input  wire logic                           game_pause,
    input  wire logic                           game_test,
    osd_status_if.src                           st
);

    logic status_diff; // new word differs from held
    logic mod_diff;

    assign status_diff = (status != st.status);
    assign mod_diff    = (core_mod != st.core_mod);

    always_ff @(posedge clk) begin
        if (rst) begin
            st.status   <= '0;   // matches the zero decode downstream
            st.core_mod <= '0;
            st.update   <= 1'b0;
        end else begin
            st.update <= 1'b0;
            if (status_valid) begin
                st.status   <= status;
                st.core_mod <= core_mod;
                st.update   <= status_diff | mod_diff; // only a real change
            end
        end
    end

    // raw controls, refreshed every cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            st.game_pause <= 1'b0; // not paused
            st.game_test  <= 1'b0;
        end else begin
            st.game_pause <= game_pause;
            st.game_test  <= game_test;
        end
    end

endmodule

`default_nettype wire

// ==== source/core_dip_decode.sv ====
/*
 * Second stage. Decodes the held OSD status and core mode into the
 * individual video, audio and control settings. Settings register on
 * update and leave with a one cycle valid. dip_pause and dip_test are
 * registered every cycle and bypass frame sync, a pause acts at once.
 * Both controls are active low.
 */
`timescale 1ns/1ps
`default_nettype none

module core_dip_decode #(
    parameter logic [video_pkg::AR_W-1:0] ARX      = video_pkg::DEF_ARX,
    parameter logic [video_pkg::AR_W-1:0] ARY      = video_pkg::DEF_ARY,
    parameter bit                         VERTICAL = 1'b0, // core can rotate
    parameter bit                         SND_EN   = 1'b0, // menu mutes apply
    parameter bit                         FLIP_EN  = 1'b0  // menu flip bit used
) (
    input  wire logic   clk,
    input  wire logic   rst,
    osd_status_if.dst   st,
    dip_settings_if.src ds,
    output logic        dip_pause,
    output logic        dip_test
);

    osd_pkg::video_mode_e         vmode;
    logic [video_pkg::SCAN_W-1:0] scan_d;
    logic                         bw_d;
    logic                         blend_d;
    logic                         tate;     // vertical game, screen rotated
    logic                         rot_d;
    logic                         flip_d;
    logic [1:0]                   ar;       // aspect ratio code
    logic [video_pkg::AR_W-1:0]   arx_d;
    logic [video_pkg::AR_W-1:0]   ary_d;

    assign vmode = osd_pkg::video_mode_e'(st.status[osd_pkg::VMODE_LO +: 2]);

    // video mode opcode to scaler controls
    always_comb begin
        case (vmode)
            osd_pkg::VM_PASS:     {scan_d, bw_d, blend_d} = {3'd0, 2'b00};
            osd_pkg::VM_LINEAR:   {scan_d, bw_d, blend_d} = {3'd0, 2'b01};
            osd_pkg::VM_ANALOGUE: {scan_d, bw_d, blend_d} = {3'd0, 2'b11};
            default:              {scan_d, bw_d, blend_d} = {3'd1, 2'b11}; // plus scan
        endcase
    end

    // core_mod[0] set for a vertical game
    assign tate   = VERTICAL & st.core_mod[0];
    assign rot_d  = VERTICAL & st.status[osd_pkg::BIT_ROT];
    assign flip_d = FLIP_EN & ~st.status[osd_pkg::BIT_FLIP];

    // code 0 keeps the native ratio, swapped on a rotated screen
    assign ar = st.status[osd_pkg::AR_LO +: 2];

    always_comb begin
        if (ar == 2'd0) begin
            arx_d = tate ? ARY : ARX;
            ary_d = tate ? ARX : ARY;
        end else begin
            arx_d = {{(video_pkg::AR_W-2){1'b0}}, ar - 2'd1}; // scaler preset
            ary_d = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // decode of an all zero status and core mode
            ds.hdmi_arx    <= ARX;
            ds.hdmi_ary    <= ARY;
            ds.rotate      <= {~FLIP_EN, 1'b0};
            ds.rot_control <= 1'b0;
            ds.en_mixing   <= 1'b1;
            ds.scanlines   <= '0;
            ds.bw_en       <= 1'b0;
            ds.blend_en    <= 1'b0;
            ds.enable_fm   <= 1'b1;
            ds.enable_psg  <= 1'b1;
            ds.osd_pause   <= 1'b0;
            ds.dip_flip    <= FLIP_EN;
            ds.dip_fxlevel <= osd_pkg::FX_INVERT;
            ds.valid       <= 1'b0;
        end else begin
            ds.valid <= st.update; // one cycle behind the change
            if (st.update) begin
                ds.hdmi_arx    <= arx_d;
                ds.hdmi_ary    <= ary_d;
                ds.rotate      <= {~flip_d, tate & ~rot_d};
                ds.rot_control <= rot_d;
                ds.en_mixing   <= ~st.status[osd_pkg::VMODE_LO]; // screen filter
                ds.scanlines   <= scan_d;
                ds.bw_en       <= bw_d;
                ds.blend_en    <= blend_d;
                ds.enable_fm   <= ~(SND_EN & st.status[osd_pkg::BIT_FM]);
                ds.enable_psg  <= ~(SND_EN & st.status[osd_pkg::BIT_PSG]);
                ds.osd_pause   <= st.status[osd_pkg::BIT_CREDITS];
                ds.dip_flip    <= flip_d;
                ds.dip_fxlevel <= st.status[osd_pkg::FX_LO +: 2] ^ osd_pkg::FX_INVERT;
            end
        end
    end

    // immediate controls, not frame synced
    always_ff @(posedge clk) begin
        if (rst) begin
            dip_pause <= 1'b1; // inactive
            dip_test  <= 1'b1;
        end else begin
            dip_pause <= ~st.game_pause;
            dip_test  <= ~(st.status[osd_pkg::BIT_TEST] | st.game_test);
        end
    end

endmodule

`default_nettype wire

// ==== source/frame_sync_apply.sv ====
/*
 * Third stage. Keeps a shadow of the newest decoded settings and
 * copies it to the outputs on vblank, so a menu change never lands
 * mid frame. A new valid while pending overwrites the shadow, the
 * latest setting wins. settings_applied pulses the cycle after a commit.
 */
`timescale 1ns/1ps
`default_nettype none

module frame_sync_apply #(
    parameter logic [video_pkg::AR_W-1:0] ARX = video_pkg::DEF_ARX,
    parameter logic [video_pkg::AR_W-1:0] ARY = video_pkg::DEF_ARY
) (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     vblank,
    dip_settings_if.dst                   ds,
    output logic [video_pkg::AR_W-1:0]    hdmi_arx,
    output logic [video_pkg::AR_W-1:0]    hdmi_ary,
    output logic [1:0]                    rotate,
    output logic                          rot_control,
    output logic                          en_mixing,
    output logic [video_pkg::SCAN_W-1:0]  scanlines,
    output logic                          bw_en,
    output logic                          blend_en,
    output logic                          enable_fm,
    output logic                          enable_psg,
    output logic                          osd_pause,
    output logic                          dip_flip,
    output logic [1:0]                    dip_fxlevel,
    output logic                          settings_applied
);

    // all settings packed, same order as the output concatenation
    localparam int SET_W = 2 * video_pkg::AR_W + video_pkg::SCAN_W + 12;

    video_pkg::apply_state_e state_q;
    logic [SET_W-1:0]        pending;  // decode stage values
    logic [SET_W-1:0]        shadow_q; // waits for vblank
    logic [SET_W-1:0]        live_q;   // what the video side sees

    assign pending = {ds.hdmi_arx, ds.hdmi_ary, ds.rotate, ds.rot_control,
                      ds.en_mixing, ds.scanlines, ds.bw_en, ds.blend_en,
                      ds.enable_fm, ds.enable_psg, ds.osd_pause, ds.dip_flip,
                      ds.dip_fxlevel};

    assign {hdmi_arx, hdmi_ary, rotate, rot_control, en_mixing, scanlines,
            bw_en, blend_en, enable_fm, enable_psg, osd_pause, dip_flip,
            dip_fxlevel} = live_q;

    // newest decode, overwritten by each valid
    always_ff @(posedge clk) begin
        if (ds.valid) begin
            shadow_q <= pending;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q          <= video_pkg::AP_IDLE;
            settings_applied <= 1'b0;
            // zero decode; flip and rotate follow the decode stage, also in reset
            live_q <= {ARX, ARY, ds.rotate, 1'b0, 1'b1, {video_pkg::SCAN_W{1'b0}},
                       1'b0, 1'b0, 1'b1, 1'b1, 1'b0, ds.dip_flip, osd_pkg::FX_INVERT};
        end else begin
            settings_applied <= 1'b0;
            case (state_q)
                video_pkg::AP_IDLE: begin
                    if (ds.valid) state_q <= video_pkg::AP_PENDING;
                end
                default: begin
                    if (vblank) begin
                        live_q           <= shadow_q; // commit at frame edge
                        settings_applied <= 1'b1;
                        // a valid on the same edge keeps us waiting for the next frame
                        state_q <= ds.valid ? video_pkg::AP_PENDING : video_pkg::AP_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/osd_dip_top.sv ====
/*
 * OSD dip settings path, top level.
 * status word in, frame synced video and audio settings out, plus the
 * immediate pause and test controls. Core options are set here and
 * handed to the stages.
 */
`timescale 1ns/1ps
`default_nettype none

module osd_dip_top #(
    parameter logic [video_pkg::AR_W-1:0] ARX      = video_pkg::DEF_ARX,
    parameter logic [video_pkg::AR_W-1:0] ARY      = video_pkg::DEF_ARY,
    parameter bit                         VERTICAL = 1'b0,
    parameter bit                         SND_EN   = 1'b0,
    parameter bit                         FLIP_EN  = 1'b0
) (
    input  wire logic                           clk,
    input  wire logic                           rst,
    input  wire logic [osd_pkg::STATUS_W-1:0]   status,
    input  wire logic                           status_valid,
    input  wire logic [osd_pkg::CORE_MOD_W-1:0] core_mod,
    input  wire logic                           game_pause,
    input  wire logic                           game_test,
    input  wire logic                           vblank,
    output logic [video_pkg::AR_W-1:0]          hdmi_arx,
    output logic [video_pkg::AR_W-1:0]          hdmi_ary,
    output logic [1:0]                          rotate,
    output logic                                rot_control,
    output logic                                en_mixing,
    output logic [video_pkg::SCAN_W-1:0]        scanlines,
    output logic                                bw_en,
    output logic                                blend_en,
    output logic                                enable_fm,
    output logic                                enable_psg,
    output logic                                osd_pause,
    output logic                                dip_flip,
    output logic [1:0]                          dip_fxlevel,
    output logic                                dip_pause,  // active low
    output logic                                dip_test,   // active low
    output logic                                settings_applied
);

    osd_status_if   st_if (); // latch to decode
    dip_settings_if ds_if (); // decode to apply

    osd_status_latch i_latch (
        .clk          (clk),
        .rst          (rst),
        .status       (status),
        .status_valid (status_valid),
        .core_mod     (core_mod),
        .game_pause   (game_pause),
        .game_test    (game_test),
        .st           (st_if.src)
    );

    core_dip_decode #(
        .ARX      (ARX),
        .ARY      (ARY),
        .VERTICAL (VERTICAL),
        .SND_EN   (SND_EN),
        .FLIP_EN  (FLIP_EN)
    ) i_decode (
        .clk       (clk),
        .rst       (rst),
        .st        (st_if.dst),
        .ds        (ds_if.src),
        .dip_pause (dip_pause),
        .dip_test  (dip_test)
    );

    frame_sync_apply #(
        .ARX (ARX),
        .ARY (ARY)
    ) i_apply (
        .clk              (clk),
        .rst              (rst),
        .vblank           (vblank),
        .ds               (ds_if.dst),
        .hdmi_arx         (hdmi_arx),
        .hdmi_ary         (hdmi_ary),
        .rotate           (rotate),
        .rot_control      (rot_control),
        .en_mixing        (en_mixing),
        .scanlines        (scanlines),
        .bw_en            (bw_en),
        .blend_en         (blend_en),
        .enable_fm        (enable_fm),
        .enable_psg       (enable_psg),
        .osd_pause        (osd_pause),
        .dip_flip         (dip_flip),
        .dip_fxlevel      (dip_fxlevel),
        .settings_applied (settings_applied)
    );

endmodule

`default_nettype wire

// ==== verif/tb_osd_dip.sv ====
/*
 * Testbench for the OSD dip settings path.
 * a stimulus table is applied row by row, each row followed by a
 * vblank, and all outputs are compared with a reference decode at the
 * settings_applied pulse. Extra phases cover the immediate controls,
 * a repeated status word and two updates before one vblank.
 */
`timescale 1ns/1ps
`default_nettype none

module tb_osd_dip;

    localparam logic [11:0] ARX = 12'd4;
    localparam logic [11:0] ARY = 12'd3;
    localparam bit VERTICAL = 1'b1;
    localparam bit SND_EN   = 1'b1;
    localparam bit FLIP_EN  = 1'b1;
    localparam int N_FIXED   = 16;
    localparam int N_ROWS    = 32;
    localparam int MAX_DELAY = 6;   // vblank delay range is 2 to 6
    localparam int TIMEOUT_CYCLES = N_ROWS * (MAX_DELAY + 10) + 20;

    logic clk, rst, status_valid, game_pause, game_test, vblank;
    logic [31:0] status;
    logic [6:0]  core_mod;
    logic [11:0] hdmi_arx, hdmi_ary;
    logic [1:0]  rotate, dip_fxlevel;
    logic [2:0]  scanlines;
    logic rot_control, en_mixing, bw_en, blend_en, enable_fm, enable_psg;
    logic osd_pause, dip_flip, dip_pause, dip_test, settings_applied;

    // expected values from the reference decode
    logic [11:0] exp_arx, exp_ary;
    logic [1:0]  exp_rotate, exp_fx;
    logic [2:0]  exp_scanlines;
    logic exp_rot_control, exp_en_mixing, exp_bw, exp_blend, exp_fm, exp_psg;
    logic exp_osd_pause, exp_flip, exp_pause, exp_test;

    // stimulus table
    logic [31:0] row_status [N_ROWS];
    logic [6:0]  row_mod    [N_ROWS];
    logic        row_pause  [N_ROWS];
    logic        row_test   [N_ROWS];
    int          row_delay  [N_ROWS];

    int n_checks = 0;
    int n_errors = 0;
    int cycle_count = 0;
    logic [31:0] seed = 32'd46;

    osd_dip_top #(
        .ARX (ARX), .ARY (ARY), .VERTICAL (VERTICAL), .SND_EN (SND_EN), .FLIP_EN (FLIP_EN)
    ) i_dut (
        .clk (clk), .rst (rst), .status (status), .status_valid (status_valid),
        .core_mod (core_mod), .game_pause (game_pause), .game_test (game_test),
        .vblank (vblank), .hdmi_arx (hdmi_arx), .hdmi_ary (hdmi_ary), .rotate (rotate),
        .rot_control (rot_control), .en_mixing (en_mixing), .scanlines (scanlines),
        .bw_en (bw_en), .blend_en (blend_en), .enable_fm (enable_fm),
        .enable_psg (enable_psg), .osd_pause (osd_pause), .dip_flip (dip_flip),
        .dip_fxlevel (dip_fxlevel), .dip_pause (dip_pause), .dip_test (dip_test),
        .settings_applied (settings_applied)
    );

    always #20 clk = ~clk; // 40 ns period

    // run limit, budget per row is generous
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles, settings_applied never arrived", cycle_count);
            $display("TB FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic next_cycle; // inputs change 2 ns after the edge
        @(posedge clk);
        #2;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("Fail %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    // reference decode of the menu word
    task automatic compute_expected(input logic [31:0] s, input logic [6:0] m,
                                    input logic p, input logic t);
        logic       tate;
        logic [1:0] vm;
        logic [1:0] ar;
        tate = VERTICAL && m[0];
        vm   = s[osd_pkg::VMODE_LO +: 2];
        ar   = s[osd_pkg::AR_LO +: 2];
        exp_blend       = (vm != 2'd0);        // every mode but pass
        exp_bw          = (vm >= 2'd2);        // both analogue modes
        exp_scanlines   = (vm == 2'd3) ? 3'd1 : 3'd0;
        exp_en_mixing   = ~s[osd_pkg::VMODE_LO];
        exp_fx          = s[osd_pkg::FX_LO +: 2] ^ 2'b10;
        exp_psg         = SND_EN ? ~s[osd_pkg::BIT_PSG] : 1'b1;
        exp_fm          = SND_EN ? ~s[osd_pkg::BIT_FM] : 1'b1;
        exp_osd_pause   = s[osd_pkg::BIT_CREDITS];
        exp_flip        = FLIP_EN ? ~s[osd_pkg::BIT_FLIP] : 1'b0;
        exp_rot_control = VERTICAL ? s[osd_pkg::BIT_ROT] : 1'b0;
        exp_rotate      = {~exp_flip, tate & ~exp_rot_control};
        if (ar == 2'd0) begin
            exp_arx = tate ? ARY : ARX; // swapped on a vertical game
            exp_ary = tate ? ARX : ARY;
        end else begin
            exp_arx = 12'(ar) - 12'd1;
            exp_ary = 12'd0;
        end
        exp_pause = ~p;
        exp_test  = ~(s[osd_pkg::BIT_TEST] | t);
    endtask

    task automatic check_settings;
        check_value("hdmi_arx", hdmi_arx, exp_arx);
        check_value("hdmi_ary", hdmi_ary, exp_ary);
        check_value("rotate", rotate, exp_rotate);
        check_value("rot_control", rot_control, exp_rot_control);
        check_value("en_mixing", en_mixing, exp_en_mixing);
        check_value("scanlines", scanlines, exp_scanlines);
        check_value("bw_en", bw_en, exp_bw);
        check_value("blend_en", blend_en, exp_blend);
        check_value("enable_fm", enable_fm, exp_fm);
        check_value("enable_psg", enable_psg, exp_psg);
        check_value("osd_pause", osd_pause, exp_osd_pause);
        check_value("dip_flip", dip_flip, exp_flip);
        check_value("dip_fxlevel", dip_fxlevel, exp_fx);
    endtask

    task automatic check_controls;
        check_value("dip_pause", dip_pause, exp_pause);
        check_value("dip_test", dip_test, exp_test);
    endtask

    task automatic send_status(input logic [31:0] s, input logic [6:0] m);
        status       = s;
        core_mod     = m;
        status_valid = 1'b1;
        next_cycle;
        status_valid = 1'b0;
    endtask

    task automatic pulse_vblank;
        vblank = 1'b1;
        next_cycle;
        vblank = 1'b0;
    endtask

    task automatic wait_applied; // bounded by the run limit
        while (!settings_applied) next_cycle;
    endtask

    task automatic add_row(input int i, input logic [31:0] s, input logic [6:0] m,
                           input logic p, input logic t, input int d);
        row_status[i] = s;
        row_mod[i]    = m;
        row_pause[i]  = p;
        row_test[i]   = t;
        row_delay[i]  = d;
    endtask

    task automatic load_table;
        add_row(0,  32'h0000_0008, 7'd0, 0, 0, 2); // linear
        add_row(1,  32'h0000_0010, 7'd0, 0, 0, 3); // analogue
        add_row(2,  32'h0000_0018, 7'd1, 0, 0, 4); // scan, swapped default ratio
        add_row(3,  32'h0000_0040, 7'd0, 1, 0, 2); // fx levels
        add_row(4,  32'h0000_0080, 7'd0, 0, 1, 5);
        add_row(5,  32'h0000_00c0, 7'd0, 0, 0, 6);
        add_row(6,  32'h0000_0100, 7'd0, 0, 0, 2); // psg off
        add_row(7,  32'h0000_0200, 7'd0, 0, 0, 3); // fm off
        add_row(8,  32'h0000_0300, 7'd0, 0, 0, 2);
        add_row(9,  32'h0000_0002, 7'd0, 0, 0, 4); // flip bit
        add_row(10, 32'h0000_0004, 7'd1, 0, 0, 2); // rot control on a vertical game
        add_row(11, 32'h0000_0006, 7'd0, 0, 0, 3);
        add_row(12, 32'h0000_4000, 7'd1, 0, 0, 2); // ratio codes 1 to 3
        add_row(13, 32'h0000_8000, 7'd0, 0, 0, 6);
        add_row(14, 32'h0000_c400, 7'd1, 0, 0, 2); // plus test bit
        add_row(15, 32'h0000_1000, 7'd1, 1, 1, 3); // credits pause
        for (int i = N_FIXED; i < N_ROWS; i++) begin
            seed = lcg_next(seed);
            row_status[i] = seed;
            seed = lcg_next(seed);
            row_mod[i]   = seed[22:16];
            row_pause[i] = seed[24];
            row_test[i]  = seed[25];
            row_delay[i] = 2 + int'(seed[30:28]) % 5;
            if (i == N_ROWS - 1)
                row_status[i][osd_pkg::BIT_TEST] = 1'b0; // game_test stays visible
            if (row_status[i] == row_status[i-1] && row_mod[i] == row_mod[i-1])
                row_status[i] = row_status[i] ^ 32'h1; // force a real change
        end
    endtask

    task automatic apply_row(input int i);
        game_pause = row_pause[i];
        game_test  = row_test[i];
        send_status(row_status[i], row_mod[i]);
        repeat (row_delay[i]) next_cycle;
        check_settings; // still the previous frame's settings
        check_value("settings_applied", settings_applied, 0);
        pulse_vblank;
        wait_applied;
        compute_expected(row_status[i], row_mod[i], row_pause[i], row_test[i]);
        check_settings;
        check_controls;
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        status = '0;
        status_valid = 1'b0;
        core_mod = '0;
        game_pause = 1'b0;
        game_test = 1'b0;
        vblank = 1'b0;
        load_table;
        repeat (8) next_cycle;
        rst = 1'b0;
        // reset defaults
        compute_expected(32'h0, 7'h0, 1'b0, 1'b0);
        repeat (3) begin
            next_cycle;
            check_value("settings_applied", settings_applied, 0);
        end
        check_settings;
        check_controls;
        for (int i = 0; i < N_ROWS; i++) apply_row(i);
        // pause and test act without a vblank
        game_pause = ~game_pause;
        game_test  = ~game_test;
        compute_expected(status, core_mod, game_pause, game_test);
        repeat (3) begin
            next_cycle;
            check_value("settings_applied", settings_applied, 0);
        end
        check_controls;
        check_settings;
        // identical status, no commit
        send_status(status, core_mod);
        repeat (2) next_cycle;
        pulse_vblank;
        repeat (10) begin
            check_value("settings_applied", settings_applied, 0);
            next_cycle;
        end
        // two words before one vblank, the second one wins
        send_status(32'h0000_0048, 7'd0);
        send_status(32'h0000_c31e, 7'd1);
        repeat (3) next_cycle;
        pulse_vblank;
        wait_applied;
        compute_expected(32'h0000_c31e, 7'd1, game_pause, game_test);
        check_settings;
        check_controls;
        repeat (5) begin
            next_cycle;
            check_value("settings_applied", settings_applied, 0); // one pulse only
        end
        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== osd_dip.f ====
source/osd_pkg.sv
source/video_pkg.sv
source/osd_status_if.sv
source/dip_settings_if.sv
source/osd_status_latch.sv
source/core_dip_decode.sv
source/frame_sync_apply.sv
source/osd_dip_top.sv
verif/tb_osd_dip.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the osd_dip testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_osd_dip \
    -f osd_dip.f -o tb_osd_dip

out=$(./obj_dir/tb_osd_dip)
echo "$out"

if echo "$out" | grep -q "TB PASSED"; then
    exit 0
fi
exit 1
